/* logic/cpu_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core-wide sizes, reset pc and memory timing
// include wherever one of the macros is used
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and data width
`define XLEN 32

// byte address width of the memory bus
`define ADDR_W 18

// general registers, x0 included
`define NUM_REGS 32

// first fetch address
`define RESET_PC 32'h0000_0000

// edges from driving a read address to sampling its byte
`define READ_LATENCY 2

// a write here ends a program
`define HALT_ADDR 18'h30004

`endif

/* logic/cpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction formats, decode result and memory request types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

package cpu_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered, bit 0 implied zero
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, read through whichever format applies
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [3:0] {
		cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
		cls_load, cls_store, cls_op_imm, cls_op_reg, cls_illegal
	} op_class_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
		alu_and, alu_or, alu_xor, alu_slt, alu_sltu
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_byte, mem_half, mem_word
	} mem_size_e;

	typedef struct packed {
		op_class_e        op_class;
		logic [4:0]       rd;
		logic [4:0]       rs1;
		logic [4:0]       rs2;
		logic [2:0]       funct3;
		logic [`XLEN-1:0] imm;
		alu_op_e          alu_op;
	} dec_t;

	typedef struct packed {
		logic               write;
		mem_size_e          size;
		logic [`ADDR_W-1:0] addr;
		logic [`XLEN-1:0]   wdata;
	} mem_req_t;

endpackage

/* logic/alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer operations and branch condition
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] b,
	input  alu_op_e          op,
	input  logic [2:0]       funct3,
	output logic [`XLEN-1:0] result,
	output logic             branch_taken
);

	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;

	assign shamt = b[4:0];
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_sll:  result = a << shamt;
			alu_srl:  result = a >> shamt;
			alu_sra:  result = $unsigned($signed(a) >>> shamt);
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_slt:  result = `XLEN'(lt);
			alu_sltu: result = `XLEN'(ltu);
			default:  result = a + b;
		endcase
	end

	// beq bne blt bge bltu bgeu
	always_comb begin
		case (funct3)
			3'b000:  branch_taken = eq;
			3'b001:  branch_taken = !eq;
			3'b100:  branch_taken = lt;
			3'b101:  branch_taken = !lt;
			3'b110:  branch_taken = ltu;
			3'b111:  branch_taken = !ltu;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

/* logic/reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// general registers, two read ports and one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module reg_file (
	input  logic             clk_in,
	input  logic             rdy_in,
	input  logic [4:0]       rs1_addr,
	input  logic [4:0]       rs2_addr,
	input  logic             we,
	input  logic [4:0]       wr_addr,
	input  logic [`XLEN-1:0] wr_data,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// x0 is never written
	always_ff @(posedge clk_in) begin
		if (rdy_in && we && (wr_addr != 5'd0))
			regs[wr_addr] <= wr_data;
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* logic/instr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational decode of one instruction word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module instr_decode import cpu_pkg::*; (
	input  instr_u instr,
	output dec_t   dec
);

	logic [`XLEN-1:0] imm_i;

	function automatic alu_op_e map_alu(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign imm_i = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};

	always_comb begin
		dec.op_class = cls_illegal;
		dec.rd = instr.r.rd;
		dec.rs1 = instr.r.rs1;
		dec.rs2 = instr.r.rs2;
		dec.funct3 = instr.r.funct3;
		dec.imm = '0;
		dec.alu_op = alu_add;
		case (instr.r.opcode)
			7'b0110111: begin
				dec.op_class = cls_lui;
				dec.imm = {instr.u.imm, 12'b0};
			end
			7'b0010111: begin
				dec.op_class = cls_auipc;
				dec.imm = {instr.u.imm, 12'b0};
			end
			7'b1101111: begin
				dec.op_class = cls_jal;
				dec.imm = {{(`XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12,
					instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			end
			7'b1100111: begin
				dec.op_class = cls_jalr;
				dec.imm = imm_i;
			end
			7'b1100011: begin
				dec.op_class = cls_branch;
				dec.imm = {{(`XLEN-12){instr.b.imm_12}}, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
				// bltu and bgeu compare unsigned
				dec.alu_op = instr.b.funct3[1] ? alu_sltu : alu_slt;
			end
			7'b0000011: begin
				dec.op_class = cls_load;
				dec.imm = imm_i;
			end
			7'b0100011: begin
				dec.op_class = cls_store;
				dec.imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			end
			7'b0010011: begin
				dec.op_class = cls_op_imm;
				dec.imm = imm_i;
				// bit 30 only selects sra here, addi has no subtract form
				dec.alu_op = map_alu(instr.i.funct3,
					(instr.i.funct3 == 3'b101) && instr.r.funct7[5]);
			end
			7'b0110011: begin
				dec.op_class = cls_op_reg;
				dec.alu_op = map_alu(instr.r.funct3, instr.r.funct7[5]);
			end
			default: dec.op_class = cls_illegal;
		endcase
	end

endmodule

/* logic/mem_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-serial memory engine, one request at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module mem_port import cpu_pkg::*; (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               rdy_in,
	input  mem_req_t           req,
	input  logic               req_valid,
	input  logic [7:0]         mem_din,
	output logic [7:0]         mem_dout,
	output logic [`ADDR_W-1:0] mem_a,
	output logic               mem_wr,
	output logic [`XLEN-1:0]   rdata,
	output logic               done
);

	logic                     busy;
	logic                     is_write;
	logic [2:0]               nbytes;
	logic [2:0]               issued;
	logic [2:0]               sampled;
	logic [`ADDR_W-1:0]       base;
	logic [`XLEN-1:0]         wdata;
	logic [`READ_LATENCY-1:0] in_flight;
	logic [2:0]               req_bytes;
	logic                     issue_more;
	logic                     issue_rd;
	logic                     sample_now;

	always_comb begin
		case (req.size)
			mem_byte: req_bytes = 3'd1;
			mem_half: req_bytes = 3'd2;
			default:  req_bytes = 3'd4;
		endcase
	end

	assign issue_more = busy && (issued != nbytes);
	assign issue_rd = (req_valid && !req.write) || (issue_more && !is_write);
	// one bit per read address still waiting for its byte
	assign sample_now = in_flight[`READ_LATENCY-1];

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			busy <= 1'b0;
			done <= 1'b0;
			mem_wr <= 1'b0;
			mem_a <= '0;
			in_flight <= '0;
		end else if (rdy_in) begin
			done <= 1'b0;
			in_flight <= {in_flight[`READ_LATENCY-2:0], issue_rd};
			if (req_valid) begin
				// first byte goes out in the same cycle the request is taken
				busy <= 1'b1;
				is_write <= req.write;
				nbytes <= req_bytes;
				base <= req.addr;
				wdata <= req.wdata;
				issued <= 3'd1;
				sampled <= 3'd0;
				rdata <= '0;
				mem_a <= req.addr;
				mem_wr <= req.write;
				mem_dout <= req.wdata[7:0];
			end else if (issue_more) begin
				issued <= issued + 3'd1;
				mem_a <= base + `ADDR_W'(issued);
				mem_wr <= is_write;
				mem_dout <= wdata[8*issued[1:0] +: 8];
			end else if (busy && is_write) begin
				// last write byte was taken at this edge
				mem_wr <= 1'b0;
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (sample_now) begin
				rdata[8*sampled[1:0] +: 8] <= mem_din;
				sampled <= sampled + 3'd1;
				if (sampled == nbytes - 3'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/core_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc, instruction register and the per-instruction sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module core_control import cpu_pkg::*; (
	input  logic             clk_in,
	input  logic             rst_in,
	input  logic             rdy_in,
	input  dec_t             dec,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	input  logic [`XLEN-1:0] alu_result,
	input  logic             branch_taken,
	input  logic [`XLEN-1:0] rdata,
	input  logic             done,
	output instr_u           instr,
	output logic             rd_we,
	output logic [4:0]       rd_addr,
	output logic [`XLEN-1:0] rd_data,
	output logic [`XLEN-1:0] alu_a,
	output logic [`XLEN-1:0] alu_b,
	output alu_op_e          alu_op,
	output mem_req_t         req,
	output logic             req_valid
);

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_memory, st_writeback
	} state_e;

	state_e           state;
	logic             booted;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] npc;
	logic [`XLEN-1:0] rs1_q;
	logic [`XLEN-1:0] rs2_q;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] load_val;

	assign pc_plus4 = pc + `XLEN'(4);

	// lui adds its immediate to zero, auipc to the instruction's pc
	assign alu_a = (dec.op_class == cls_lui) ? '0 :
		(dec.op_class == cls_auipc) ? pc : rs1_q;
	assign alu_b = (dec.op_class inside {cls_op_reg, cls_branch}) ? rs2_q : dec.imm;
	assign alu_op = dec.alu_op;

	always_comb begin
		case (dec.op_class)
			cls_jal:    target = pc + dec.imm;
			cls_jalr:   target = alu_result & ~`XLEN'(1);
			cls_branch: target = branch_taken ? pc + dec.imm : pc_plus4;
			default:    target = pc_plus4;
		endcase
	end

	// unused bytes of rdata arrive as zero, so zero-extension is free
	always_comb begin
		case (dec.funct3)
			3'b000:  load_val = {{(`XLEN-8){rdata[7]}}, rdata[7:0]};
			3'b001:  load_val = {{(`XLEN-16){rdata[15]}}, rdata[15:0]};
			default: load_val = rdata;
		endcase
	end

	assign rd_we = (state == st_writeback);
	assign rd_addr = dec.rd;

	task automatic start_fetch(input logic [`XLEN-1:0] addr);
		pc <= addr;
		req.write <= 1'b0;
		req.size <= mem_word;
		req.addr <= addr[`ADDR_W-1:0];
		req_valid <= 1'b1;
		state <= st_fetch;
	endtask

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= st_fetch;
			booted <= 1'b0;
			pc <= `RESET_PC;
			req_valid <= 1'b0;
		end else if (rdy_in) begin
			req_valid <= 1'b0;
			case (state)
				st_fetch: begin
					// first fetch after reset has no preceding transition
					if (!booted) begin
						booted <= 1'b1;
						start_fetch(pc);
					end else if (done) begin
						instr <= rdata;
						state <= st_decode;
					end
				end
				st_decode: begin
					rs1_q <= rs1_data;
					rs2_q <= rs2_data;
					state <= st_execute;
				end
				st_execute: begin
					npc <= target;
					rd_data <= (dec.op_class inside {cls_jal, cls_jalr}) ? pc_plus4 : alu_result;
					case (dec.op_class)
						cls_load, cls_store: begin
							req.write <= (dec.op_class == cls_store);
							req.size <= (dec.funct3[1:0] == 2'b00) ? mem_byte :
								(dec.funct3[1:0] == 2'b01) ? mem_half : mem_word;
							req.addr <= alu_result[`ADDR_W-1:0];
							req.wdata <= rs2_q;
							req_valid <= 1'b1;
							state <= st_memory;
						end
						// illegal words fall through as a no-op
						cls_branch, cls_illegal: start_fetch(target);
						default: state <= st_writeback;
					endcase
				end
				st_memory: begin
					if (done) begin
						rd_data <= load_val;
						if (dec.op_class == cls_store)
							start_fetch(npc);
						else
							state <= st_writeback;
					end
				end
				st_writeback: start_fetch(npc);
			endcase
		end
	end

endmodule

/* logic/cpu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multi-cycle RV32I core on a byte-wide memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               rdy_in,
	input  logic [7:0]         mem_din,
	output logic [7:0]         mem_dout,
	output logic [`ADDR_W-1:0] mem_a,
	output logic               mem_wr
);

	instr_u           instr;
	dec_t             dec;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic             rd_we;
	logic [4:0]       rd_addr;
	logic [`XLEN-1:0] rd_data;
	logic [`XLEN-1:0] alu_a;
	logic [`XLEN-1:0] alu_b;
	alu_op_e          alu_op;
	logic [`XLEN-1:0] alu_result;
	logic             branch_taken;
	mem_req_t         req;
	logic             req_valid;
	logic [`XLEN-1:0] rdata;
	logic             done;

	// port names of the sequencer match the nets here
	core_control core_control_i (.*);

	instr_decode instr_decode_i (
		.instr (instr),
		.dec   (dec)
	);

	reg_file reg_file_i (
		.clk_in   (clk_in),
		.rdy_in   (rdy_in),
		.rs1_addr (dec.rs1),
		.rs2_addr (dec.rs2),
		.we       (rd_we),
		.wr_addr  (rd_addr),
		.wr_data  (rd_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu alu_i (
		.a            (alu_a),
		.b            (alu_b),
		.op           (alu_op),
		.funct3       (dec.funct3),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

	mem_port mem_port_i (.*);

endmodule

/* verification/cpu_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus checks, bound into every mem_port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module cpu_properties (
	input logic               clk_in,
	input logic               rst_in,
	input logic               rdy_in,
	input logic [7:0]         mem_dout,
	input logic [`ADDR_W-1:0] mem_a,
	input logic               mem_wr,
	input logic               done,
	input logic               busy
);

	wr_low_after_reset: assert property (@(posedge clk_in) rst_in |=> !mem_wr)
		else $error("mem_wr high in the cycle after reset");

	// a stalled edge must leave the bus untouched
	bus_held_in_stall: assert property (@(posedge clk_in) disable iff (rst_in)
		!rdy_in |=> ($stable(mem_a) && $stable(mem_wr) && $stable(mem_dout)))
		else $error("bus outputs changed while rdy_in was low");

	done_only_when_busy: assert property (@(posedge clk_in) disable iff (rst_in)
		$rose(done) |-> $past(busy))
		else $error("done raised while the engine was idle");

endmodule

bind mem_port cpu_properties props_i (.*);

/* verification/cpu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random RV32I programs against a reference ISS, byte writes compared
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_settings.svh"

module cpu_tb;

	localparam int NUM_PROGS = 4;
	localparam int ITEMS = 30;
	localparam int MAX_INSTR = 200;
	localparam int MEM_SIZE = 1 << `ADDR_W;
	localparam longint WATCHDOG = longint'(NUM_PROGS) * 2 * MAX_INSTR * 40 * 2 * 10;

	logic               clk_in = 1'b0;
	logic               rst_in;
	logic               rdy_in;
	logic [7:0]         mem_din;
	logic [7:0]         mem_dout;
	logic [`ADDR_W-1:0] mem_a;
	logic               mem_wr;

	logic [7:0]         image [MEM_SIZE];
	logic [7:0]         mem [MEM_SIZE];
	logic [7:0]         ref_mem [MEM_SIZE];
	logic [31:0]        prog [$];
	logic [`ADDR_W-1:0] mdl_addr [$];
	logic [7:0]         mdl_data [$];
	logic [`ADDR_W-1:0] exp_addr [$];
	logic [7:0]         exp_data [$];
	int                 errors;
	bit                 halted;
	bit                 first_pending;
	bit                 fetch_end;
	bit                 pending_valid;
	logic [7:0]         pending;

	cpu_top dut_i (
		.clk_in   (clk_in),
		.rst_in   (rst_in),
		.rdy_in   (rdy_in),
		.mem_din  (mem_din),
		.mem_dout (mem_dout),
		.mem_a    (mem_a),
		.mem_wr   (mem_wr)
	);

	always #5 clk_in = ~clk_in;

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + $urandom % 15);
	endfunction

	// word offset into the store area at 0x10000
	function automatic logic [11:0] word_off();
		return 12'(($urandom % 64) * 4);
	endfunction

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a) ^ 8'(a >> 8) ^ {6'b0, 2'(a >> 16)} ^ 8'h5a;
	endfunction

	task automatic build_program();
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          sz;
		prog.delete();
		for (int r = 1; r < 16; r++) begin
			prog.push_back({20'($urandom), 5'(r), 7'h37});
			prog.push_back(enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), 7'h13));
		end
		// x29 load area, x30 store area, x31 halt page
		prog.push_back({20'h00020, 5'd29, 7'h37});
		prog.push_back({20'h00010, 5'd30, 7'h37});
		prog.push_back({20'h00030, 5'd31, 7'h37});
		for (int k = 0; k < ITEMS; k++) begin
			rd = pick_reg();
			rs = pick_reg();
			case ($urandom % 4)
				0: begin
					f3 = 3'($urandom);
					case ($urandom % 4)
						0: prog.push_back({20'($urandom), rd, 7'h37});
						1: prog.push_back({20'($urandom), rd, 7'h17});
						2: begin
							imm = 12'($urandom);
							if (f3 == 3'd1)
								imm = {7'b0, imm[4:0]};
							else if (f3 == 3'd5)
								imm = {1'b0, imm[10], 5'b0, imm[4:0]};
							prog.push_back(enc_i(imm, rs, f3, rd, 7'h13));
						end
						default: begin
							imm[0] = (f3 == 3'd0 || f3 == 3'd5) && $urandom % 2;
							prog.push_back(enc_r({1'b0, imm[0], 5'b0}, pick_reg(), rs, f3, rd));
						end
					endcase
					prog.push_back(enc_s(word_off(), rd, 5'd30, 3'd2));
				end
				1: begin
					case ($urandom % 3)
						0: begin
							f3 = 3'($urandom);
							if (f3 inside {3'd2, 3'd3})
								f3 = 3'd0;
							// equal operands now and then so both outcomes occur
							prog.push_back(enc_b(13'd8, ($urandom % 4 == 0) ? rs : rd, rs, f3));
						end
						1: prog.push_back(enc_j(21'd8, rd));
						default: begin
							prog.push_back({20'h0, rs, 7'h17});
							prog.push_back(enc_i(12'd12, rs, 3'd0, rd, 7'h67));
						end
					endcase
					// first marker sits on the skipped path
					prog.push_back(enc_s(word_off(), pick_reg(), 5'd30, 3'd2));
					prog.push_back(enc_s(word_off(), rd, 5'd30, 3'd2));
				end
				2: begin
					f3 = 3'($urandom % 5);
					if (f3 == 3'd3)
						f3 = 3'd5;
					sz = 1 << f3[1:0];
					imm = 12'(($urandom % 256) & ~(sz - 1));
					prog.push_back(enc_i(imm, 5'd29, f3, rd, 7'h03));
					prog.push_back(enc_s(word_off(), rd, 5'd30, 3'd2));
				end
				default: begin
					f3 = 3'($urandom % 3);
					sz = 1 << f3;
					imm = 12'(($urandom % 256) & ~(sz - 1));
					prog.push_back(enc_s(imm, rs, 5'd30, f3));
				end
			endcase
		end
		prog.push_back(enc_s(12'd4, 5'd0, 5'd31, 3'd0));
		for (int a = 0; a < MEM_SIZE; a++)
			image[a] = fill_byte(a);
		for (int a = 'h20000; a < 'h20100; a++)
			image[a] = 8'($urandom);
		foreach (prog[i])
			for (int b = 0; b < 4; b++)
				image[4 * i + b] = prog[i][8 * b +: 8];
	endtask

	function automatic logic [7:0] ref_byte(input logic [31:0] a);
		return ref_mem[a[`ADDR_W-1:0]];
	endfunction

	// instruction-set model that records its own byte writes
	task automatic run_model();
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] v;
		logic [31:0] a;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [`ADDR_W-1:0] ea;
		bit          stop;
		bit          wr;
		bit          taken;
		stop = 0;
		pc = `RESET_PC;
		foreach (x[i])
			x[i] = '0;
		for (int a2 = 0; a2 < MEM_SIZE; a2++)
			ref_mem[a2] = image[a2];
		mdl_addr.delete();
		mdl_data.delete();
		for (int step = 0; step < MAX_INSTR && !stop; step++) begin
			ins = {ref_byte(pc + 3), ref_byte(pc + 2), ref_byte(pc + 1), ref_byte(pc)};
			f3 = ins[14:12];
			rd = ins[11:7];
			s1 = x[ins[19:15]];
			s2 = x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			wr = 1;
			v = '0;
			a = pc + 4;
			case (ins[6:0])
				7'h37: v = {ins[31:12], 12'b0};
				7'h17: v = pc + {ins[31:12], 12'b0};
				7'h6f: begin
					v = pc + 4;
					a = pc + imm_j;
				end
				7'h67: begin
					v = pc + 4;
					a = (s1 + imm_i) & ~32'd1;
				end
				7'h63: begin
					wr = 0;
					case (f3)
						3'd0: taken = (s1 == s2);
						3'd1: taken = (s1 != s2);
						3'd4: taken = ($signed(s1) < $signed(s2));
						3'd5: taken = ($signed(s1) >= $signed(s2));
						3'd6: taken = (s1 < s2);
						default: taken = (s1 >= s2);
					endcase
					if (taken)
						a = pc + imm_b;
				end
				7'h03: begin
					for (int b = 0; b < (1 << f3[1:0]); b++)
						v[8 * b +: 8] = ref_byte(s1 + imm_i + b);
					if (f3 == 3'd0)
						v = {{24{v[7]}}, v[7:0]};
					else if (f3 == 3'd1)
						v = {{16{v[15]}}, v[15:0]};
				end
				7'h23: begin
					wr = 0;
					for (int b = 0; b < (1 << f3[1:0]); b++) begin
						ea = `ADDR_W'(s1 + imm_s + b);
						mdl_addr.push_back(ea);
						mdl_data.push_back(s2[8 * b +: 8]);
						ref_mem[ea] = s2[8 * b +: 8];
						if (ea == `HALT_ADDR)
							stop = 1;
					end
				end
				7'h13, 7'h33: begin
					if (ins[6:0] == 7'h13)
						s2 = imm_i;
					case (f3)
						3'd0: v = (ins[5] && ins[30]) ? s1 - s2 : s1 + s2;
						3'd1: v = s1 << s2[4:0];
						3'd2: v = 32'($signed(s1) < $signed(s2));
						3'd3: v = 32'(s1 < s2);
						3'd4: v = s1 ^ s2;
						3'd5: v = ins[30] ? $unsigned($signed(s1) >>> s2[4:0]) : s1 >> s2[4:0];
						3'd6: v = s1 | s2;
						default: v = s1 & s2;
					endcase
				end
				default: wr = 0;
			endcase
			if (wr && rd != 5'd0)
				x[rd] = v;
			pc = a;
		end
		if (!stop) begin
			errors++;
			$display("reference model never reached the halt store");
		end
	endtask

	task automatic check_write(input logic [`ADDR_W-1:0] addr, input logic [7:0] data);
		logic [`ADDR_W-1:0] ea;
		logic [7:0]         ed;
		if (exp_addr.size() == 0) begin
			errors++;
			$display("byte write to %h after the expected sequence was used up", addr);
			return;
		end
		ea = exp_addr.pop_front();
		ed = exp_data.pop_front();
		if (addr !== ea) begin
			errors++;
			$display("ERR mem_a exp %h got %h", ea, addr);
		end
		if (data !== ed) begin
			errors++;
			$display("ERR mem_dout exp %h got %h", ed, data);
		end
	endtask

	// mem_a rests at zero until the first fetch walks up from RESET_PC
	task automatic check_fetch(input logic [`ADDR_W-1:0] addr, output bit last);
		logic [`ADDR_W-1:0] lo;
		logic [`ADDR_W-1:0] hi;
		lo = `ADDR_W'(`RESET_PC);
		hi = lo + `ADDR_W'(3);
		last = (addr == hi);
		if (addr !== '0 && (addr < lo || addr > hi)) begin
			errors++;
			$display("ERR mem_a exp %h to %h got %h", lo, hi, addr);
			last = 1;
		end
	endtask

	// memory takes the bus at the edge and drives read data at the next falling edge
	always @(posedge clk_in) begin
		if (!rst_in && rdy_in) begin
			if (first_pending) begin
				check_fetch(mem_a, fetch_end);
				if (mem_wr !== 1'b0) begin
					errors++;
					$display("memory write seen before the first fetch completed");
				end
				if (fetch_end)
					first_pending = 0;
			end
			if (mem_wr) begin
				mem[mem_a] = mem_dout;
				if (!halted)
					check_write(mem_a, mem_dout);
				if (mem_a == `HALT_ADDR)
					halted = 1;
			end else begin
				pending = mem[mem_a];
				pending_valid = 1;
			end
		end
	end

	always @(negedge clk_in) begin
		if (pending_valid) begin
			mem_din = pending;
			pending_valid = 0;
		end
	end

	task automatic run_program(input bit stall);
		for (int a = 0; a < MEM_SIZE; a++)
			mem[a] = image[a];
		exp_addr = mdl_addr;
		exp_data = mdl_data;
		rst_in = 1'b1;
		rdy_in = 1'b1;
		halted = 0;
		repeat (8) @(negedge clk_in);
		rst_in = 1'b0;
		first_pending = 1;
		while (!halted) begin
			@(negedge clk_in);
			rdy_in = stall ? ($urandom % 4 != 0) : 1'b1;
		end
		rdy_in = 1'b1;
		if (exp_addr.size() != 0) begin
			errors++;
			$display("program halted with %0d expected writes missing", exp_addr.size());
		end
	endtask

	initial begin
		void'($urandom(32'hcd09e5a2));
		rst_in = 1'b1;
		rdy_in = 1'b1;
		mem_din = 8'h00;
		errors = 0;
		halted = 0;
		first_pending = 0;
		fetch_end = 0;
		pending_valid = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			build_program();
			run_model();
			run_program(1'b0);
			run_program(1'b1);
		end
		$display("checks done, errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before all programs halted");
		$display("Simulation failed");
		$finish;
	end

endmodule

/* cpu_top.f */
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/mem_port.sv
logic/core_control.sv
logic/cpu_top.sv
verification/cpu_properties.sv
verification/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the core and its testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu_top.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
